// ==== rtl/i2c_wbs_pkg.sv ====
package i2c_wbs_pkg;

    // Basic payload types
    typedef logic [7:0]  byte_t;
    typedef logic [2:0]  reg_addr_t;
    typedef logic [15:0] prescale_t;
    typedef logic [6:0]  i2c_addr_t;

    // One command entry, address in the upper bits
    typedef struct packed {
        i2c_addr_t addr;
        logic      start;
        logic      read;
        logic      write;
        logic      stop;
    } cmd_t;

    // Register map, 0x05 is reserved and reads zero
    localparam reg_addr_t REG_STATUS      = 3'd0;
    localparam reg_addr_t REG_FIFO_STATUS = 3'd1;
    localparam reg_addr_t REG_CMD_ADDR    = 3'd2;
    localparam reg_addr_t REG_CMD         = 3'd3;
    localparam reg_addr_t REG_DATA        = 3'd4;
    localparam reg_addr_t REG_PRESCALE_LO = 3'd6;
    localparam reg_addr_t REG_PRESCALE_HI = 3'd7;

    // Command register bits, bit 3 unused
    localparam int CMD_BIT_START = 0;
    localparam int CMD_BIT_READ  = 1;
    localparam int CMD_BIT_WRITE = 2;
    localparam int CMD_BIT_STOP  = 4;

    // Status register bits
    localparam int ST_BIT_BUSY     = 0;
    localparam int ST_BIT_BUS_CONT = 1;
    localparam int ST_BIT_BUS_ACT  = 2;
    localparam int ST_BIT_MISS_ACK = 3;

    // FIFO status register bits
    localparam int FS_BIT_CMD_EMPTY = 0;
    localparam int FS_BIT_CMD_FULL  = 1;
    localparam int FS_BIT_CMD_OVF   = 2;
    localparam int FS_BIT_WR_EMPTY  = 3;
    localparam int FS_BIT_WR_FULL   = 4;
    localparam int FS_BIT_WR_OVF    = 5;
    localparam int FS_BIT_RD_EMPTY  = 6;
    localparam int FS_BIT_RD_FULL   = 7;

endpackage

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  ADDR_WIDTH = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    output payload_t out_data_o,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output logic     full_o,
    output logic     empty_o
);

    localparam logic [ADDR_WIDTH:0] DEPTH = {1'b1, {ADDR_WIDTH{1'b0}}};

    payload_t              mem [2**ADDR_WIDTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   count;
    logic [ADDR_WIDTH:0]   count_next;
    logic                  full_q;
    logic                  empty_q;
    logic                  ready_q;
    logic                  push;
    logic                  pop;

    // Transfers on both sides
    assign push = in_valid_i & ready_q;
    assign pop  = ~empty_q & out_ready_i;

    // Fill level after this edge
    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // Pointers, level and flags
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
            // Input side stays closed until reset is released
            ready_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count_next;
            full_q  <= (count_next == DEPTH);
            empty_q <= (count_next == '0);
            ready_q <= (count_next != DEPTH);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    // Show-ahead head of queue
    assign out_data_o  = mem[rd_ptr];
    assign out_valid_o = ~empty_q;
    assign in_ready_o  = ready_q;
    assign full_o      = full_q;
    assign empty_o     = empty_q;

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= DEPTH)
        else $error("stream_fifo level above depth");

    // Head must not move while the consumer stalls
    a_head_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
        else $error("stream_fifo head changed under back-pressure");

endmodule

// ==== rtl/wbs_regs.sv ====
`timescale 1ns/1ps

module wbs_regs import i2c_wbs_pkg::*; #(
    parameter prescale_t DEFAULT_PRESCALE = 16'd1,
    parameter bit        FIXED_PRESCALE   = 1'b0
) (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t wbs_adr_i,
    input  byte_t     wbs_dat_i,
    input  logic      wbs_we_i,
    input  logic      wbs_stb_i,
    input  logic      wbs_cyc_i,
    output byte_t     wbs_dat_o,
    output logic      wbs_ack_o,
    output cmd_t      cmd_o,
    output logic      cmd_valid_o,
    input  logic      cmd_ready_i,
    output byte_t     wr_data_o,
    output logic      wr_valid_o,
    input  logic      wr_ready_i,
    input  byte_t     rd_data_i,
    input  logic      rd_empty_i,
    output logic      rd_pop_o,
    input  logic      cmd_empty_i,
    input  logic      wr_empty_i,
    input  logic      rd_full_i,
    input  logic      busy_i,
    input  logic      bus_control_i,
    input  logic      bus_active_i,
    input  logic      missed_ack_i,
    output prescale_t prescale_o
);

    logic      ack_q;
    logic      access;
    logic      wr_access;
    logic      rd_access;
    cmd_t      cmd_reg;
    cmd_t      cmd_new;
    cmd_t      cmd_q;
    logic      cmd_valid_q;
    logic      cmd_push_req;
    logic      cmd_load;
    byte_t     wr_q;
    logic      wr_valid_q;
    logic      wr_push_req;
    logic      wr_load;
    logic      rd_pop_q;
    prescale_t prescale_q;
    logic      missed_ack_q;
    logic      cmd_ovf_q;
    logic      wr_ovf_q;
    byte_t     rd_mux;

    // One access per strobe
    // Acknowledge toggles while strobe is held
    assign access    = wbs_cyc_i & wbs_stb_i & ~ack_q;
    assign wr_access = access & wbs_we_i;
    assign rd_access = access & ~wbs_we_i;

    // Bus flags with the held address
    always_comb begin
        cmd_new       = cmd_reg;
        cmd_new.start = wbs_dat_i[CMD_BIT_START];
        cmd_new.read  = wbs_dat_i[CMD_BIT_READ];
        cmd_new.write = wbs_dat_i[CMD_BIT_WRITE];
        cmd_new.stop  = wbs_dat_i[CMD_BIT_STOP];
    end

    // Empty command is not queued
    assign cmd_push_req = wr_access && (wbs_adr_i == REG_CMD) &&
                          (cmd_new.start | cmd_new.read | cmd_new.write | cmd_new.stop);
    assign wr_push_req  = wr_access && (wbs_adr_i == REG_DATA);

    // Load only into a free or draining slot
    assign cmd_load = cmd_push_req & (~cmd_valid_q | cmd_ready_i);
    assign wr_load  = wr_push_req & (~wr_valid_q | wr_ready_i);

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q        <= 1'b0;
            cmd_valid_q  <= 1'b0;
            wr_valid_q   <= 1'b0;
            rd_pop_q     <= 1'b0;
            prescale_q   <= DEFAULT_PRESCALE;
            missed_ack_q <= 1'b0;
            cmd_ovf_q    <= 1'b0;
            wr_ovf_q     <= 1'b0;
        end else begin
            ack_q        <= access;
            cmd_valid_q  <= cmd_load | (cmd_valid_q & ~cmd_ready_i);
            wr_valid_q   <= wr_load | (wr_valid_q & ~wr_ready_i);
            // Pop read FIFO one edge after the data was sampled
            rd_pop_q     <= rd_access && (wbs_adr_i == REG_DATA) && !rd_empty_i;
            missed_ack_q <= missed_ack_q | missed_ack_i;
            if (cmd_push_req && !cmd_ready_i) begin
                cmd_ovf_q <= 1'b1;
            end
            if (wr_push_req && !wr_ready_i) begin
                wr_ovf_q <= 1'b1;
            end
            if (wr_access) begin
                case (wbs_adr_i)
                    REG_STATUS: begin
                        // Write 1 to clear
                        // A pulse in the same cycle wins
                        if (wbs_dat_i[ST_BIT_MISS_ACK]) begin
                            missed_ack_q <= missed_ack_i;
                        end
                    end
                    REG_FIFO_STATUS: begin
                        if (wbs_dat_i[FS_BIT_CMD_OVF]) begin
                            cmd_ovf_q <= 1'b0;
                        end
                        if (wbs_dat_i[FS_BIT_WR_OVF]) begin
                            wr_ovf_q <= 1'b0;
                        end
                    end
                    REG_PRESCALE_LO: begin
                        if (!FIXED_PRESCALE) begin
                            prescale_q[7:0] <= wbs_dat_i;
                        end
                    end
                    REG_PRESCALE_HI: begin
                        if (!FIXED_PRESCALE) begin
                            prescale_q[15:8] <= wbs_dat_i;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Holding and read-back data
    always_ff @(posedge clk) begin
        if (wr_access && wbs_adr_i == REG_CMD_ADDR) begin
            cmd_reg.addr <= wbs_dat_i[6:0];
        end
        if (wr_access && wbs_adr_i == REG_CMD) begin
            cmd_reg <= cmd_new;
        end
        if (cmd_load) begin
            cmd_q <= cmd_new;
        end
        if (wr_load) begin
            wr_q <= wbs_dat_i;
        end
        if (rd_access) begin
            wbs_dat_o <= rd_mux;
        end
    end

    // Read data select
    always_comb begin
        rd_mux = '0;
        case (wbs_adr_i)
            REG_STATUS: begin
                rd_mux[ST_BIT_BUSY]     = busy_i;
                rd_mux[ST_BIT_BUS_CONT] = bus_control_i;
                rd_mux[ST_BIT_BUS_ACT]  = bus_active_i;
                rd_mux[ST_BIT_MISS_ACK] = missed_ack_q;
            end
            REG_FIFO_STATUS: begin
                rd_mux[FS_BIT_CMD_EMPTY] = cmd_empty_i;
                rd_mux[FS_BIT_CMD_FULL]  = ~cmd_ready_i;
                rd_mux[FS_BIT_CMD_OVF]   = cmd_ovf_q;
                rd_mux[FS_BIT_WR_EMPTY]  = wr_empty_i;
                rd_mux[FS_BIT_WR_FULL]   = ~wr_ready_i;
                rd_mux[FS_BIT_WR_OVF]    = wr_ovf_q;
                rd_mux[FS_BIT_RD_EMPTY]  = rd_empty_i;
                rd_mux[FS_BIT_RD_FULL]   = rd_full_i;
            end
            REG_CMD_ADDR: rd_mux = {1'b0, cmd_reg.addr};
            REG_CMD: begin
                rd_mux[CMD_BIT_START] = cmd_reg.start;
                rd_mux[CMD_BIT_READ]  = cmd_reg.read;
                rd_mux[CMD_BIT_WRITE] = cmd_reg.write;
                rd_mux[CMD_BIT_STOP]  = cmd_reg.stop;
            end
            REG_DATA:        rd_mux = rd_data_i;
            REG_PRESCALE_LO: rd_mux = prescale_q[7:0];
            REG_PRESCALE_HI: rd_mux = prescale_q[15:8];
            default:         rd_mux = '0;
        endcase
    end

    assign wbs_ack_o   = ack_q;
    assign cmd_o       = cmd_q;
    assign cmd_valid_o = cmd_valid_q;
    assign wr_data_o   = wr_q;
    assign wr_valid_o  = wr_valid_q;
    assign rd_pop_o    = rd_pop_q;
    assign prescale_o  = prescale_q;

    a_ack_single: assert property (@(posedge clk) disable iff (rst) wbs_ack_o |=> !wbs_ack_o)
        else $error("wbs_regs acknowledge held two cycles");

    // Read FIFO must still hold the byte when the pop lands
    a_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
        $rose(rd_pop_o) |-> !rd_empty_i)
        else $error("wbs_regs pop issued on empty read FIFO");

endmodule

// ==== rtl/i2c_master_wbs.sv ====
`timescale 1ns/1ps

module i2c_master_wbs import i2c_wbs_pkg::*; #(
    parameter prescale_t DEFAULT_PRESCALE      = 16'd1,
    parameter bit        FIXED_PRESCALE        = 1'b0,
    parameter int        CMD_FIFO_ADDR_WIDTH   = 5,
    parameter int        WRITE_FIFO_ADDR_WIDTH = 5,
    parameter int        READ_FIFO_ADDR_WIDTH  = 5
) (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t wbs_adr_i,
    input  byte_t     wbs_dat_i,
    input  logic      wbs_we_i,
    input  logic      wbs_stb_i,
    input  logic      wbs_cyc_i,
    output byte_t     wbs_dat_o,
    output logic      wbs_ack_o,
    output cmd_t      cmd_o,
    output logic      cmd_valid_o,
    input  logic      cmd_ready_i,
    output byte_t     wr_data_o,
    output logic      wr_valid_o,
    input  logic      wr_ready_i,
    input  byte_t     rd_data_i,
    input  logic      rd_valid_i,
    output logic      rd_ready_o,
    input  logic      busy_i,
    input  logic      bus_control_i,
    input  logic      bus_active_i,
    input  logic      missed_ack_i,
    output prescale_t prescale_o
);

    // Register block to command FIFO
    cmd_t  regs_cmd;
    logic  regs_cmd_valid;
    logic  cmd_fifo_ready;
    logic  cmd_fifo_empty;
    // Register block to write FIFO
    byte_t regs_wr_data;
    logic  regs_wr_valid;
    logic  wr_fifo_ready;
    logic  wr_fifo_empty;
    // Read FIFO head back to the register block
    byte_t rd_fifo_data;
    logic  rd_fifo_empty;
    logic  rd_fifo_full;
    logic  rd_pop;

    wbs_regs #(
        .DEFAULT_PRESCALE (DEFAULT_PRESCALE),
        .FIXED_PRESCALE   (FIXED_PRESCALE)
    ) regs (
        .clk           (clk),
        .rst           (rst),
        .wbs_adr_i     (wbs_adr_i),
        .wbs_dat_i     (wbs_dat_i),
        .wbs_we_i      (wbs_we_i),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_cyc_i     (wbs_cyc_i),
        .wbs_dat_o     (wbs_dat_o),
        .wbs_ack_o     (wbs_ack_o),
        .cmd_o         (regs_cmd),
        .cmd_valid_o   (regs_cmd_valid),
        .cmd_ready_i   (cmd_fifo_ready),
        .wr_data_o     (regs_wr_data),
        .wr_valid_o    (regs_wr_valid),
        .wr_ready_i    (wr_fifo_ready),
        .rd_data_i     (rd_fifo_data),
        .rd_empty_i    (rd_fifo_empty),
        .rd_pop_o      (rd_pop),
        .cmd_empty_i   (cmd_fifo_empty),
        .wr_empty_i    (wr_fifo_empty),
        .rd_full_i     (rd_fifo_full),
        .busy_i        (busy_i),
        .bus_control_i (bus_control_i),
        .bus_active_i  (bus_active_i),
        .missed_ack_i  (missed_ack_i),
        .prescale_o    (prescale_o)
    );

    // Full of cmd and write FIFOs is seen as low ready
    stream_fifo #(.payload_t(cmd_t), .ADDR_WIDTH(CMD_FIFO_ADDR_WIDTH)) cmd_fifo (
        .clk(clk), .rst(rst),
        .in_data_i(regs_cmd), .in_valid_i(regs_cmd_valid), .in_ready_o(cmd_fifo_ready),
        .out_data_o(cmd_o), .out_valid_o(cmd_valid_o), .out_ready_i(cmd_ready_i),
        .full_o(), .empty_o(cmd_fifo_empty)
    );

    stream_fifo #(.payload_t(byte_t), .ADDR_WIDTH(WRITE_FIFO_ADDR_WIDTH)) write_fifo (
        .clk(clk), .rst(rst),
        .in_data_i(regs_wr_data), .in_valid_i(regs_wr_valid), .in_ready_o(wr_fifo_ready),
        .out_data_o(wr_data_o), .out_valid_o(wr_valid_o), .out_ready_i(wr_ready_i),
        .full_o(), .empty_o(wr_fifo_empty)
    );

    // Engine pushes, host reads of 0x04 pop
    stream_fifo #(.payload_t(byte_t), .ADDR_WIDTH(READ_FIFO_ADDR_WIDTH)) read_fifo (
        .clk(clk), .rst(rst),
        .in_data_i(rd_data_i), .in_valid_i(rd_valid_i), .in_ready_o(rd_ready_o),
        .out_data_o(rd_fifo_data), .out_valid_o(), .out_ready_i(rd_pop),
        .full_o(rd_fifo_full), .empty_o(rd_fifo_empty)
    );

endmodule

// ==== bench/tb_host_tasks.svh ====
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Cycles before a missing acknowledge or stream flag counts as an error
localparam int ACK_LIMIT = 16;

// One bus access, returns 2 ns after the acknowledge edge
task automatic host_access(input logic we, input reg_addr_t adr, input byte_t dat,
                           output byte_t rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    wbs_adr_i = adr;
    wbs_dat_i = dat;
    wbs_we_i  = we;
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    do begin
        @(posedge clk);
        #2;
        waited++;
    end while (!wbs_ack_o && waited < ACK_LIMIT);
    if (!wbs_ack_o) begin
        $display("No acknowledge for register %0d in test %s", adr, test_name);
        error_count++;
    end
    rdata = wbs_dat_o;
    // Strobe drops in the cycle after the acknowledge
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i  = 1'b0;
endtask

task automatic host_write(input reg_addr_t adr, input byte_t dat);
    byte_t unused;
    host_access(1'b1, adr, dat, unused);
endtask

task automatic host_read(input reg_addr_t adr, output byte_t dat);
    host_access(1'b0, adr, 8'h00, dat);
endtask

// Bounded wait; 0 command valid, 1 write valid, else read ready
task automatic wait_for_stream(input int sel);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < ACK_LIMIT) begin
        case (sel)
            0:       seen = cmd_valid_o;
            1:       seen = wr_valid_o;
            default: seen = rd_ready_o;
        endcase
        if (!seen) begin
            @(posedge clk);
            #2;
            waited++;
        end
    end
    if (!seen) begin
        $display("Stream %0d never raised its flag in test %s", sel, test_name);
        error_count++;
    end
endtask

task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
    check_count++;
    assert (act === exp)
    else begin
        $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
        error_count++;
    end
endtask

task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = error_count;
endtask

task automatic finish_test();
    if (error_count == errors_at_start) begin
        $display("test %s: ok, %0d checks so far", test_name, check_count);
    end else begin
        $display("test %s: %0d errors", test_name, error_count - errors_at_start);
    end
endtask

// All handshakes idle and prescale at default once reset drops
a_reset_idle: assert property (@(posedge clk) $fell(rst) |->
    !wbs_ack_o && !cmd_valid_o && !wr_valid_o && !rd_ready_o &&
    prescale_o == DEFAULT_PRESCALE)
    else begin
        $display("Outputs were not idle when reset was released");
        error_count++;
    end

// Acknowledge only answers a request sampled one edge earlier
a_ack_answers: assert property (@(posedge clk) disable iff (rst)
    wbs_ack_o |-> $past(wbs_cyc_i && wbs_stb_i))
    else begin
        $display("Acknowledge without a request in test %s", test_name);
        error_count++;
    end

`endif

// ==== bench/tb_i2c_master_wbs.sv ====
`timescale 1ns/1ps

module tb_i2c_master_wbs import i2c_wbs_pkg::*; ();

    localparam prescale_t DEFAULT_PRESCALE = 16'd1;
    localparam int        N_TESTS          = 6;
    localparam int        CYCLES_PER_TEST  = 300;

    logic      clk;
    logic      rst;
    reg_addr_t wbs_adr_i;
    byte_t     wbs_dat_i;
    logic      wbs_we_i;
    logic      wbs_stb_i;
    logic      wbs_cyc_i;
    byte_t     wbs_dat_o;
    logic      wbs_ack_o;
    cmd_t      cmd_o;
    logic      cmd_valid_o;
    logic      cmd_ready_i;
    byte_t     wr_data_o;
    logic      wr_valid_o;
    logic      wr_ready_i;
    byte_t     rd_data_i;
    logic      rd_valid_i;
    logic      rd_ready_o;
    logic      busy_i;
    logic      bus_control_i;
    logic      bus_active_i;
    logic      missed_ack_i;
    prescale_t prescale_o;

    // Bookkeeping
    integer seed;
    string  test_name;
    int     error_count = 0;
    int     check_count = 0;
    int     errors_at_start = 0;
    // Scratch for the test sequence
    byte_t  rd;
    byte_t  b;
    cmd_t   exp_cmd;
    int     n;
    byte_t  exp_q[$];

    i2c_master_wbs #(
        .DEFAULT_PRESCALE      (DEFAULT_PRESCALE),
        .FIXED_PRESCALE        (1'b0),
        .CMD_FIFO_ADDR_WIDTH   (2),
        .WRITE_FIFO_ADDR_WIDTH (2),
        .READ_FIFO_ADDR_WIDTH  (2)
    ) DUT (.*);

    `include "tb_host_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit from test count and per-test budget
    initial begin
        repeat (N_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Watchdog expired after %0d cycles in test %s",
                 N_TESTS * CYCLES_PER_TEST, test_name);
        $display("Simulation FAILED");
        $finish;
    end

    // Status byte as the register map lays it out
    function automatic byte_t status_byte(input logic busy, input logic cont,
                                          input logic act, input logic miss);
        byte_t s;
        s                  = '0;
        s[ST_BIT_BUSY]     = busy;
        s[ST_BIT_BUS_CONT] = cont;
        s[ST_BIT_BUS_ACT]  = act;
        s[ST_BIT_MISS_ACK] = miss;
        return s;
    endfunction

    // Engine side push, held until the read FIFO takes it
    task automatic push_read_byte(input byte_t val);
        rd_data_i  = val;
        rd_valid_i = 1'b1;
        wait_for_stream(2);
        @(posedge clk);
        #2;
        rd_valid_i = 1'b0;
    endtask

    // Open the consumer and count entries until the stream runs dry
    task automatic drain_stream(input bit use_cmd, output int count);
        count = 0;
        cmd_ready_i = use_cmd;
        wr_ready_i  = !use_cmd;
        while ((use_cmd ? cmd_valid_o : wr_valid_o) && count < ACK_LIMIT) begin
            count++;
            @(posedge clk);
            #2;
        end
        cmd_ready_i = 1'b0;
        wr_ready_i  = 1'b0;
    endtask

    // Stalled consumer, five writes into a four-entry FIFO
    task automatic overflow_case(input bit use_cmd);
        int    drained;
        int    full_bit;
        int    ovf_bit;
        byte_t st;
        full_bit = use_cmd ? FS_BIT_CMD_FULL : FS_BIT_WR_FULL;
        ovf_bit  = use_cmd ? FS_BIT_CMD_OVF : FS_BIT_WR_OVF;
        host_read(REG_FIFO_STATUS, st);
        check_value("overflow flag before fill", 1'b0, st[ovf_bit]);
        // Fifth entry waits in the holding register
        repeat (5) begin
            if (use_cmd) begin
                host_write(REG_CMD, byte_t'(1 << CMD_BIT_READ));
            end else begin
                host_write(REG_DATA, byte_t'($random(seed)));
            end
        end
        host_read(REG_FIFO_STATUS, st);
        check_value("full flag", 1'b1, st[full_bit]);
        check_value("overflow flag", 1'b1, st[ovf_bit]);
        host_write(REG_FIFO_STATUS, byte_t'(1 << ovf_bit));
        host_read(REG_FIFO_STATUS, st);
        check_value("overflow flag after clear", 1'b0, st[ovf_bit]);
        drain_stream(use_cmd, drained);
        check_value("entries drained", 16'd5, drained);
    endtask

    initial begin
        seed          = 32'h667b_0ba2;
        rst           = 1'b1;
        wbs_adr_i     = '0;
        wbs_dat_i     = '0;
        wbs_we_i      = 1'b0;
        wbs_stb_i     = 1'b0;
        wbs_cyc_i     = 1'b0;
        cmd_ready_i   = 1'b0;
        wr_ready_i    = 1'b0;
        rd_data_i     = '0;
        rd_valid_i    = 1'b0;
        busy_i        = 1'b0;
        bus_control_i = 1'b0;
        bus_active_i  = 1'b0;
        missed_ack_i  = 1'b0;
        test_name     = "reset";
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("prescale");
        check_value("prescale_o after reset", DEFAULT_PRESCALE, prescale_o);
        host_read(REG_PRESCALE_LO, rd);
        check_value("prescale low", DEFAULT_PRESCALE[7:0], rd);
        host_read(REG_PRESCALE_HI, rd);
        check_value("prescale high", DEFAULT_PRESCALE[15:8], rd);
        host_write(REG_PRESCALE_LO, 8'h34);
        host_write(REG_PRESCALE_HI, 8'h12);
        host_read(REG_PRESCALE_LO, rd);
        check_value("prescale low", 8'h34, rd);
        host_read(REG_PRESCALE_HI, rd);
        check_value("prescale high", 8'h12, rd);
        check_value("prescale_o", 16'h1234, prescale_o);
        // Reserved address
        host_read(3'd5, rd);
        check_value("reserved register", 8'h00, rd);
        finish_test();

        start_test("command");
        host_write(REG_CMD_ADDR, 8'h55);
        // Start, write and stop, plus the unused bit 3
        host_write(REG_CMD, 8'h1D);
        exp_cmd.addr  = 7'h55;
        exp_cmd.start = 1'b1;
        exp_cmd.read  = 1'b0;
        exp_cmd.write = 1'b1;
        exp_cmd.stop  = 1'b1;
        wait_for_stream(0);
        check_value("cmd_o", exp_cmd, cmd_o);
        host_read(REG_CMD, rd);
        check_value("command readback", 8'h15, rd);
        host_read(REG_CMD_ADDR, rd);
        check_value("address readback", 8'h55, rd);
        drain_stream(1'b1, n);
        check_value("commands queued", 16'd1, n);
        // Bit 3 alone is no command
        host_write(REG_CMD, 8'h08);
        host_read(REG_FIFO_STATUS, rd);
        check_value("cmd_empty", 1'b1, rd[FS_BIT_CMD_EMPTY]);
        check_value("cmd_valid_o", 1'b0, cmd_valid_o);
        finish_test();

        start_test("write_data");
        exp_q.delete();
        exp_q.push_back(8'hA1);
        exp_q.push_back(8'h5C);
        exp_q.push_back(8'h3E);
        foreach (exp_q[i]) begin
            host_write(REG_DATA, exp_q[i]);
        end
        wait_for_stream(1);
        wr_ready_i = 1'b1;
        while (wr_valid_o && exp_q.size() > 0) begin
            check_value("wr_data_o", exp_q.pop_front(), wr_data_o);
            @(posedge clk);
            #2;
        end
        wr_ready_i = 1'b0;
        check_value("write bytes not seen", 16'd0, exp_q.size());
        finish_test();

        start_test("overflow");
        overflow_case(1'b1);
        overflow_case(1'b0);
        finish_test();

        start_test("read_data");
        exp_q.delete();
        repeat (4) begin
            b = byte_t'($random(seed));
            exp_q.push_back(b);
            push_read_byte(b);
        end
        check_value("rd_ready_o when full", 1'b0, rd_ready_o);
        host_read(REG_FIFO_STATUS, rd);
        check_value("rd_full", 1'b1, rd[FS_BIT_RD_FULL]);
        check_value("rd_empty", 1'b0, rd[FS_BIT_RD_EMPTY]);
        repeat (4) begin
            host_read(REG_DATA, rd);
            check_value("read byte", exp_q.pop_front(), rd);
        end
        host_read(REG_FIFO_STATUS, rd);
        check_value("rd_empty after reads", 1'b1, rd[FS_BIT_RD_EMPTY]);
        check_value("rd_full after reads", 1'b0, rd[FS_BIT_RD_FULL]);
        finish_test();

        start_test("status");
        busy_i       = 1'b1;
        bus_active_i = 1'b1;
        host_read(REG_STATUS, rd);
        check_value("status", status_byte(1'b1, 1'b0, 1'b1, 1'b0), rd);
        busy_i        = 1'b0;
        bus_control_i = 1'b1;
        bus_active_i  = 1'b0;
        host_read(REG_STATUS, rd);
        check_value("status", status_byte(1'b0, 1'b1, 1'b0, 1'b0), rd);
        // One-cycle missed acknowledge from the engine
        missed_ack_i = 1'b1;
        @(posedge clk);
        #2;
        missed_ack_i = 1'b0;
        host_read(REG_STATUS, rd);
        check_value("status after pulse", status_byte(1'b0, 1'b1, 1'b0, 1'b1), rd);
        host_read(REG_STATUS, rd);
        check_value("status still sticky", status_byte(1'b0, 1'b1, 1'b0, 1'b1), rd);
        host_write(REG_STATUS, byte_t'(1 << ST_BIT_MISS_ACK));
        host_read(REG_STATUS, rd);
        check_value("status after clear", status_byte(1'b0, 1'b1, 1'b0, 1'b0), rd);
        finish_test();

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 N_TESTS, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+bench
rtl/i2c_wbs_pkg.sv
rtl/stream_fifo.sv
rtl/wbs_regs.sv
rtl/i2c_master_wbs.sv
bench/tb_i2c_master_wbs.sv
